/* Makefile */
# Verilator build and run of the peripheral bus testbench

VERILATOR ?= verilator
TOP       ?= tb_peripheral_bus
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/bus_pkg.sv */
/*
 * Bus widths and the enums shared by the peripheral bus.
 * The address width follows the 24-bit CPU bus of the SoC.
 * One access is in flight at a time, so the state set is small.
 */

package bus_pkg;

    localparam int addr_width = 24;
    localparam int data_width = 32;
    localparam int strb_width = 4;

    // Transaction controller states, one access at a time
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_capture,
        st_respond
    } bus_state_t;

    // Target of a decoded access
    typedef enum logic [2:0] {
        sel_none,
        sel_status,
        sel_dsp,
        sel_pad,
        sel_flash_ctrl
    } periph_sel_t;

endpackage

/* hdl/bus_transaction_fsm.sv */
/*
 * Bus transaction controller, valid/ready on the CPU side.
 * Every access takes three cycles from the edge that samples valid
 * to the edge that samples ready. Valid must be held until then.
 * Unmapped accesses complete and read zero.
 */

`timescale 1ns/1ps

module bus_transaction_fsm (
    input  logic                                    vdp_clk,
    input  logic                                    vdp_reset,
    input  logic                                    cpu_mem_valid,
    input  bus_pkg::periph_sel_t                    sel,
    input  logic [mmio_map_pkg::status_width-1:0]   status_value,
    input  logic [bus_pkg::data_width-1:0]          dsp_result,
    input  logic                                    pad_bit,
    input  logic [3:0]                              flash_readback,
    output logic                                    issue,
    output logic                                    cpu_mem_ready,
    output logic [bus_pkg::data_width-1:0]          cpu_read_data
);
    import bus_pkg::*;

    bus_state_t state;
    bus_state_t next_state;
    logic [data_width-1:0] read_mux;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (cpu_mem_valid) begin
                    next_state = st_issue;
                end
            end
            // Decoder registers select and write pulse here
            st_issue:   next_state = st_capture;
            st_capture: next_state = st_respond;
            st_respond: next_state = st_idle;
            default:    next_state = st_idle;
        endcase
    end

    assign issue = (state == st_issue);
    assign cpu_mem_ready = (state == st_respond);

    // Read source by select, zero extended
    always_comb begin
        read_mux = '0;
        case (sel)
            sel_status: begin
                read_mux[$bits(status_value)-1:0] = status_value;
            end
            sel_dsp: begin
                read_mux = dsp_result;
            end
            sel_pad: begin
                read_mux[0] = pad_bit;
            end
            sel_flash_ctrl: begin
                read_mux[$bits(flash_readback)-1:0] = flash_readback;
            end
            default: begin
                read_mux = '0;
            end
        endcase
    end

    // Held stable through respond while ready is up
    always_ff @(posedge vdp_clk) begin
        if (state == st_capture) begin
            cpu_read_data <= read_mux;
        end
    end

endmodule

/* hdl/dsp_multiplier.sv */
/*
 * Signed 16x16 multiplier behind two operand registers.
 * The product is registered every cycle and is valid from the
 * second edge after an operand write. Signed operands only.
 */

`timescale 1ns/1ps

module dsp_multiplier (
    input  logic                                           vdp_clk,
    input  logic                                           dsp_write_en,
    input  logic                                           dsp_operand_b,
    input  logic [mmio_map_pkg::dsp_operand_width-1:0]     write_data,
    output logic [2*mmio_map_pkg::dsp_operand_width-1:0]   dsp_result
);
    import mmio_map_pkg::*;

    logic [dsp_operand_width-1:0] mult_a;
    logic [dsp_operand_width-1:0] mult_b;

    // Flat write enables keep the operand FFs inside the DSP block
    always_ff @(posedge vdp_clk) begin
        if (dsp_write_en && !dsp_operand_b) begin
            mult_a <= write_data;
        end

        if (dsp_write_en && dsp_operand_b) begin
            mult_b <= write_data;
        end
    end

    always_ff @(posedge vdp_clk) begin
        dsp_result <= $signed(mult_a) * $signed(mult_b);
    end

endmodule

/* hdl/io_registers.sv */
/*
 * Status LEDs, gamepad mock and bit-banged flash control.
 * The gamepad is mocked with three board buttons, the second data
 * line is not modelled. Flash pins idle with CS high and no output
 * enables whenever the control register is inactive.
 */

`timescale 1ns/1ps

module io_registers (
    input  logic                                                vdp_clk,
    input  logic                                                vdp_reset,
    input  logic                                                status_write_en,
    input  logic                                                pad_write_en,
    input  logic                                                flash_ctrl_write_en,
    input  logic [bus_pkg::data_width-1:0]                      cpu_write_data,
    input  logic                                                btn_1,
    input  logic                                                btn_2,
    input  logic                                                btn_3,
    input  logic [mmio_map_pkg::flash_ctrl_field_width-1:0]     flash_out,
    output logic [mmio_map_pkg::status_width-1:0]               status_value,
    output logic                                                led_r,
    output logic                                                led_b,
    output logic                                                pad_bit,
    output logic [mmio_map_pkg::flash_ctrl_field_width-1:0]     flash_readback,
    output logic                                                flash_clk,
    output logic                                                flash_csn,
    output logic [mmio_map_pkg::flash_ctrl_field_width-1:0]     flash_in,
    output logic [mmio_map_pkg::flash_ctrl_field_width-1:0]     flash_in_en
);
    import mmio_map_pkg::*;

    logic pad_latch;
    logic pad_clk;
    logic pad_clk_prev;
    logic [pad_shift_width-1:0] pad_shift;
    logic [pad_shift_width-1:0] pad_load;

    logic flash_ctrl_active;
    logic [flash_ctrl_field_width-1:0] flash_ctrl_in;
    logic [flash_ctrl_field_width-1:0] flash_ctrl_in_en;
    logic flash_ctrl_clk;
    logic flash_ctrl_csn;

    // Status LEDs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status_value <= status_reset_value;
        end else if (status_write_en) begin
            status_value <= cpu_write_data[status_width-1:0];
        end
    end

    assign led_r = status_value[0];
    assign led_b = status_value[1];

    // Gamepad latch and clock as written by the CPU
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk <= 1'b0;
            pad_clk_prev <= 1'b0;
        end else begin
            if (pad_write_en) begin
                pad_latch <= cpu_write_data[pad_latch_bit];
                pad_clk <= cpu_write_data[pad_clk_bit];
            end
            pad_clk_prev <= pad_clk;
        end
    end

    // Left, right and B buttons
    always_comb begin
        pad_load = '0;
        pad_load[7] = btn_1;
        pad_load[6] = btn_3;
        pad_load[0] = btn_2;
    end

    // A clock edge wins over a held latch
    always_ff @(posedge vdp_clk) begin
        if (pad_clk && !pad_clk_prev) begin
            pad_shift <= {1'b0, pad_shift[pad_shift_width-1:1]};
        end else if (pad_latch) begin
            pad_shift <= pad_load;
        end
    end

    assign pad_bit = pad_shift[0];

    // Flash control fields
    always_ff @(posedge vdp_clk) begin
        if (flash_ctrl_write_en) begin
            flash_ctrl_in <= cpu_write_data[flash_ctrl_in_lsb +: flash_ctrl_field_width];
            flash_ctrl_in_en <= cpu_write_data[flash_ctrl_in_en_lsb +: flash_ctrl_field_width];
            flash_ctrl_clk <= cpu_write_data[flash_ctrl_clk_bit];
            flash_ctrl_csn <= cpu_write_data[flash_ctrl_csn_bit];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            flash_ctrl_active <= 1'b0;
        end else if (flash_ctrl_write_en) begin
            flash_ctrl_active <= cpu_write_data[flash_ctrl_active_bit];
        end
    end

    always_ff @(posedge vdp_clk) begin
        flash_readback <= flash_out;
    end

    // Idle pins: deselected, clock low, outputs released
    assign flash_clk = flash_ctrl_active ? flash_ctrl_clk : 1'b0;
    assign flash_csn = flash_ctrl_active ? flash_ctrl_csn : 1'b1;
    assign flash_in = flash_ctrl_active ? flash_ctrl_in : '0;
    assign flash_in_en = flash_ctrl_active ? flash_ctrl_in_en : '0;

endmodule

/* hdl/mmio_decoder.sv */
/*
 * Registered address decode for the peripheral bus.
 * Outputs change only on the edge that samples issue. The select code
 * holds until the next issue, write pulses last one cycle.
 */

`timescale 1ns/1ps

module mmio_decoder (
    input  logic                              vdp_clk,
    input  logic                              vdp_reset,
    input  logic                              issue,
    input  logic [bus_pkg::addr_width-1:0]    cpu_address,
    input  logic [bus_pkg::strb_width-1:0]    cpu_wstrb,
    output bus_pkg::periph_sel_t              sel,
    output logic                              dsp_operand_b,
    output logic                              status_write_en,
    output logic                              dsp_write_en,
    output logic                              pad_write_en,
    output logic                              flash_ctrl_write_en
);
    import bus_pkg::*;
    import mmio_map_pkg::*;

    logic [region_width-1:0] region;
    periph_sel_t next_sel;
    logic is_write;

    assign region = cpu_address[region_lsb +: region_width];

    // Any strobe bit set makes it a write
    assign is_write = |cpu_wstrb;

    always_comb begin
        case (region)
            region_status:     next_sel = sel_status;
            region_dsp:        next_sel = sel_dsp;
            region_pad:        next_sel = sel_pad;
            region_flash_ctrl: next_sel = sel_flash_ctrl;
            default:           next_sel = sel_none;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            sel <= sel_none;
            status_write_en <= 1'b0;
            dsp_write_en <= 1'b0;
            pad_write_en <= 1'b0;
            flash_ctrl_write_en <= 1'b0;
        end else begin
            // issue is a single cycle, so each pulse is too
            status_write_en <= issue && is_write && (next_sel == sel_status);
            dsp_write_en <= issue && is_write && (next_sel == sel_dsp);
            pad_write_en <= issue && is_write && (next_sel == sel_pad);
            flash_ctrl_write_en <= issue && is_write && (next_sel == sel_flash_ctrl);

            if (issue) begin
                sel <= next_sel;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (issue) begin
            dsp_operand_b <= cpu_address[dsp_operand_bit];
        end
    end

endmodule

/* hdl/mmio_map_pkg.sv */
/*
 * Peripheral address map and register bit fields.
 * Only address bits 19:16 pick the region. Other bits are ignored,
 * so each region is aliased over its whole 64 KB window.
 */

package mmio_map_pkg;

    // Region field, address bits 19:16
    localparam int region_lsb = 16;
    localparam int region_width = 4;

    localparam logic [region_width-1:0] region_status = 4'd1;
    localparam logic [region_width-1:0] region_dsp = 4'd2;
    localparam logic [region_width-1:0] region_pad = 4'd3;
    localparam logic [region_width-1:0] region_flash_ctrl = 4'd4;

    // Multiplier operands, address bit 2 selects B
    localparam int dsp_operand_bit = 2;
    localparam int dsp_operand_width = 16;

    // Gamepad mock
    localparam int pad_shift_width = 16;
    localparam int pad_latch_bit = 0;
    localparam int pad_clk_bit = 1;

    // Flash control word
    localparam int flash_ctrl_field_width = 4;
    localparam int flash_ctrl_in_lsb = 0;
    localparam int flash_ctrl_in_en_lsb = 4;
    localparam int flash_ctrl_clk_bit = 8;
    localparam int flash_ctrl_csn_bit = 9;
    localparam int flash_ctrl_active_bit = 15;

    // Status LEDs, red lit after reset
    localparam int status_width = 2;
    localparam logic [status_width-1:0] status_reset_value = 2'd1;

endpackage

/* hdl/peripheral_bus.sv */
/*
 * Memory-mapped peripheral bus, top level.
 * The CPU side is a picorv32-style valid/ready bus on vdp_clk.
 * Flash pins are driven by the control register only.
 */

`timescale 1ns/1ps

module peripheral_bus (
    input  logic                               vdp_clk,
    input  logic                               vdp_reset,
    input  logic                               cpu_mem_valid,
    input  logic [bus_pkg::addr_width-1:0]     cpu_address,
    input  logic [bus_pkg::strb_width-1:0]     cpu_wstrb,
    input  logic [bus_pkg::data_width-1:0]     cpu_write_data,
    output logic                               cpu_mem_ready,
    output logic [bus_pkg::data_width-1:0]     cpu_read_data,
    input  logic                               btn_1,
    input  logic                               btn_2,
    input  logic                               btn_3,
    output logic                               led_r,
    output logic                               led_b,
    output logic                               flash_clk,
    output logic                               flash_csn,
    output logic [3:0]                         flash_in,
    output logic [3:0]                         flash_in_en,
    input  logic [3:0]                         flash_out
);

    logic issue;
    bus_pkg::periph_sel_t sel;
    logic dsp_operand_b;
    logic status_write_en;
    logic dsp_write_en;
    logic pad_write_en;
    logic flash_ctrl_write_en;

    logic [mmio_map_pkg::status_width-1:0] status_value;
    logic [bus_pkg::data_width-1:0] dsp_result;
    logic pad_bit;
    logic [3:0] flash_readback;

    bus_transaction_fsm u_fsm (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .cpu_mem_valid  (cpu_mem_valid),
        .sel            (sel),
        .status_value   (status_value),
        .dsp_result     (dsp_result),
        .pad_bit        (pad_bit),
        .flash_readback (flash_readback),
        .issue          (issue),
        .cpu_mem_ready  (cpu_mem_ready),
        .cpu_read_data  (cpu_read_data)
    );

    mmio_decoder u_decoder (
        .vdp_clk             (vdp_clk),
        .vdp_reset           (vdp_reset),
        .issue               (issue),
        .cpu_address         (cpu_address),
        .cpu_wstrb           (cpu_wstrb),
        .sel                 (sel),
        .dsp_operand_b       (dsp_operand_b),
        .status_write_en     (status_write_en),
        .dsp_write_en        (dsp_write_en),
        .pad_write_en        (pad_write_en),
        .flash_ctrl_write_en (flash_ctrl_write_en)
    );

    // Operands come from the low half of the write data
    dsp_multiplier u_dsp (
        .vdp_clk       (vdp_clk),
        .dsp_write_en  (dsp_write_en),
        .dsp_operand_b (dsp_operand_b),
        .write_data    (cpu_write_data[mmio_map_pkg::dsp_operand_width-1:0]),
        .dsp_result    (dsp_result)
    );

    io_registers u_io (
        .vdp_clk             (vdp_clk),
        .vdp_reset           (vdp_reset),
        .status_write_en     (status_write_en),
        .pad_write_en        (pad_write_en),
        .flash_ctrl_write_en (flash_ctrl_write_en),
        .cpu_write_data      (cpu_write_data),
        .btn_1               (btn_1),
        .btn_2               (btn_2),
        .btn_3               (btn_3),
        .flash_out           (flash_out),
        .status_value        (status_value),
        .led_r               (led_r),
        .led_b               (led_b),
        .pad_bit             (pad_bit),
        .flash_readback      (flash_readback),
        .flash_clk           (flash_clk),
        .flash_csn           (flash_csn),
        .flash_in            (flash_in),
        .flash_in_en         (flash_in_en)
    );

endmodule

/* verification/tb_model.svh */
/*
 * Reference model for the peripheral bus testbench.
 * Included inside the testbench module body.
 * Flash pins are packed as {clk, csn, in_en, in}.
 */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

// Signed 16x16 product, worked out in wide integers
function automatic logic [31:0] expected_product(input logic [15:0] a, input logic [15:0] b);
    longint sa;
    longint sb;
    longint prod;
    sa = a[15] ? longint'(a) - 65536 : longint'(a);
    sb = b[15] ? longint'(b) - 65536 : longint'(b);
    prod = sa * sb;
    return prod[31:0];
endfunction

// Serial pad bit after index clock pulses
function automatic logic expected_pad_bit(input int index, input logic b1, input logic b2,
                                          input logic b3);
    case (index)
        0: return b2;
        6: return b3;
        7: return b1;
        default: return 1'b0;
    endcase
endfunction

// Pins follow the control word only while bit 15 is set
function automatic logic [9:0] expected_flash_pins(input logic [15:0] ctrl);
    logic [9:0] pins;
    if (ctrl[15]) begin
        pins = {ctrl[8], ctrl[9], ctrl[7:4], ctrl[3:0]};
    end else begin
        // Deselected, clock low, nothing driven
        pins = {1'b0, 1'b1, 4'h0, 4'h0};
    end
    return pins;
endfunction

`endif

/* verification/tb_peripheral_bus.sv */
/*
 * Testbench for the peripheral bus, acting as the CPU.
 * Accesses are serial and each must finish three cycles after the
 * edge that samples valid. Random values come from a 16-bit LFSR.
 */

`timescale 1ns/1ps

module tb_peripheral_bus;
    import bus_pkg::*;
    import mmio_map_pkg::*;

    logic vdp_clk;
    logic vdp_reset;
    logic cpu_mem_valid;
    logic [addr_width-1:0] cpu_address;
    logic [strb_width-1:0] cpu_wstrb;
    logic [data_width-1:0] cpu_write_data;
    logic cpu_mem_ready;
    logic [data_width-1:0] cpu_read_data;
    logic btn_1;
    logic btn_2;
    logic btn_3;
    logic led_r;
    logic led_b;
    logic flash_clk;
    logic flash_csn;
    logic [3:0] flash_in;
    logic [3:0] flash_in_en;
    logic [3:0] flash_out;

    logic [15:0] lfsr_state;
    string name_q[$];
    logic [31:0] expected_q[$];
    logic [31:0] actual_q[$];
    time time_q[$];
    string chk_name;
    logic [31:0] chk_expected;
    logic [31:0] chk_actual;
    time chk_time;
    int check_count;
    int error_count;
    int test_check_base;
    int test_error_base;
    bit bus_stalled;

    `include "tb_model.svh"

    peripheral_bus u_peripheral_bus (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .cpu_mem_valid  (cpu_mem_valid),
        .cpu_address    (cpu_address),
        .cpu_wstrb      (cpu_wstrb),
        .cpu_write_data (cpu_write_data),
        .cpu_mem_ready  (cpu_mem_ready),
        .cpu_read_data  (cpu_read_data),
        .btn_1          (btn_1),
        .btn_2          (btn_2),
        .btn_3          (btn_3),
        .led_r          (led_r),
        .led_b          (led_b),
        .flash_clk      (flash_clk),
        .flash_csn      (flash_csn),
        .flash_in       (flash_in),
        .flash_in_en    (flash_in_en),
        .flash_out      (flash_out)
    );

    always #50 vdp_clk = ~vdp_clk;

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [addr_width-1:0] region_base(input logic [3:0] region);
        return {4'h0, region, 16'h0000};
    endfunction

    function automatic void expect_value(input string name, input logic [31:0] expected,
                                         input logic [31:0] actual);
        name_q.push_back(name);
        expected_q.push_back(expected);
        actual_q.push_back(actual);
        time_q.push_back($time);
    endfunction

    // Compares queued results away from the rising edge
    always @(negedge vdp_clk) begin
        while (name_q.size() > 0) begin
            chk_name = name_q.pop_front();
            chk_expected = expected_q.pop_front();
            chk_actual = actual_q.pop_front();
            chk_time = time_q.pop_front();
            check_count++;
            assert (chk_actual === chk_expected) else begin
                error_count++;
                $display("ERR time=%0t %s expected=%h actual=%h",
                         chk_time, chk_name, chk_expected, chk_actual);
            end
        end
    end

    // One access; rdata holds the read data when ready was seen
    task automatic bus_access(input logic [addr_width-1:0] address,
                              input logic [strb_width-1:0] wstrb,
                              input logic [data_width-1:0] data,
                              output logic [data_width-1:0] rdata);
        int edges;
        edges = 0;
        rdata = '0;
        if (bus_stalled) begin
            return;
        end
        @(posedge vdp_clk);
        cpu_mem_valid <= 1'b1;
        cpu_address <= address;
        cpu_wstrb <= wstrb;
        cpu_write_data <= data;
        do begin
            @(posedge vdp_clk);
            edges++;
        end while (!cpu_mem_ready && edges < 20);
        if (!cpu_mem_ready) begin
            $display("Timeout: cpu_mem_ready not seen within 20 cycles, address %h", address);
            bus_stalled = 1'b1;
        end else begin
            rdata = cpu_read_data;
            // Valid is sampled on the first edge
            expect_value("cpu_mem_ready edge", 32'd3, 32'(edges - 1));
        end
        cpu_mem_valid <= 1'b0;
        cpu_wstrb <= '0;
    endtask

    task automatic bus_write(input logic [addr_width-1:0] address,
                             input logic [data_width-1:0] data);
        logic [data_width-1:0] unused;
        bus_access(address, 4'hf, data, unused);
    endtask

    task automatic bus_read(input logic [addr_width-1:0] address,
                            output logic [data_width-1:0] rdata);
        bus_access(address, 4'h0, '0, rdata);
    endtask

    task automatic check_flash_pins(input logic [15:0] ctrl);
        logic [9:0] pins;
        pins = expected_flash_pins(ctrl);
        expect_value("flash_clk", 32'(pins[9]), 32'(flash_clk));
        expect_value("flash_csn", 32'(pins[8]), 32'(flash_csn));
        expect_value("flash_in_en", 32'(pins[7:4]), 32'(flash_in_en));
        expect_value("flash_in", 32'(pins[3:0]), 32'(flash_in));
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (name_q.size() > 0 && waited < 4) begin
            @(posedge vdp_clk);
            waited++;
        end
        if (name_q.size() > 0) begin
            $display("Checker queue still holds results after 4 cycles");
            error_count++;
        end
        $display("Test %s: %0d checks, %0d errors", name,
                 check_count - test_check_base, error_count - test_error_base);
        test_check_base = check_count;
        test_error_base = error_count;
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] value;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [3:0] flash_data;
        logic [3:0] region;
        $timeformat(-9, 0, " ns", 0);
        vdp_clk = 1'b0;
        vdp_reset = 1'b1;
        cpu_mem_valid = 1'b0;
        cpu_address = '0;
        cpu_wstrb = '0;
        cpu_write_data = '0;
        btn_1 = 1'b0;
        btn_2 = 1'b0;
        btn_3 = 1'b0;
        flash_out = 4'h0;
        lfsr_state = 16'd8481;
        check_count = 0;
        error_count = 0;
        test_check_base = 0;
        test_error_base = 0;
        bus_stalled = 1'b0;
        repeat (5) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        @(posedge vdp_clk);

        expect_value("led_r", 32'd1, 32'(led_r));
        expect_value("led_b", 32'd0, 32'(led_b));
        expect_value("flash_csn", 32'd1, 32'(flash_csn));
        expect_value("cpu_mem_ready", 32'd0, 32'(cpu_mem_ready));
        bus_read(region_base(region_status), rdata);
        expect_value("cpu_read_data", 32'd1, rdata);
        value = random_bits(2);
        bus_write(region_base(region_status), value);
        expect_value("led_r", 32'(value[0]), 32'(led_r));
        expect_value("led_b", 32'(value[1]), 32'(led_b));
        bus_read(region_base(region_status), rdata);
        expect_value("cpu_read_data", value, rdata);
        finish_test("reset and status");

        for (int i = 0; i < 20; i++) begin
            op_a = 16'(random_bits(16));
            op_b = 16'(random_bits(16));
            // Make sure negative operands are covered early
            if (i < 2) begin
                op_a[15] = 1'b1;
            end
            bus_write(region_base(region_dsp), {16'h0000, op_a});
            bus_write(region_base(region_dsp) | (24'd1 << dsp_operand_bit), {16'h0000, op_b});
            bus_read(region_base(region_dsp), rdata);
            expect_value("cpu_read_data", expected_product(op_a, op_b), rdata);
        end
        finish_test("dsp multiplier");

        for (int round = 0; round < 3; round++) begin
            value = random_bits(3);
            btn_1 <= value[0];
            btn_2 <= value[1];
            btn_3 <= value[2];
            bus_write(region_base(region_pad), 32'h1);
            bus_write(region_base(region_pad), 32'h0);
            for (int k = 0; k < 10; k++) begin
                if (k > 0) begin
                    bus_write(region_base(region_pad), 32'h2);
                    bus_write(region_base(region_pad), 32'h0);
                end
                bus_read(region_base(region_pad), rdata);
                expect_value("cpu_read_data",
                             32'(expected_pad_bit(k, value[0], value[1], value[2])), rdata);
            end
        end
        finish_test("gamepad");

        for (int i = 0; i < 4; i++) begin
            value = random_bits(16) | 32'h8000;
            bus_write(region_base(region_flash_ctrl), value);
            check_flash_pins(value[15:0]);
            flash_data = 4'(random_bits(4));
            flash_out <= flash_data;
            bus_read(region_base(region_flash_ctrl), rdata);
            expect_value("cpu_read_data", 32'(flash_data), rdata);
        end
        finish_test("flash active");

        for (int i = 0; i < 3; i++) begin
            bus_write(region_base(region_flash_ctrl), random_bits(16) | 32'h8000);
            value = random_bits(16) & 32'h7fff;
            bus_write(region_base(region_flash_ctrl), value);
            check_flash_pins(value[15:0]);
        end
        finish_test("flash inactive");

        for (int i = 0; i < 4; i++) begin
            value = random_bits(24);
            region = value[19:16];
            // Move mapped codes 1 to 4 up to 9 to 12
            if (region >= 4'd1 && region <= 4'd4) begin
                region = region | 4'h8;
            end
            bus_write({value[23:20], region, value[15:0]}, random_bits(32));
            bus_read({value[23:20], region, value[15:0]}, rdata);
            expect_value("cpu_read_data", 32'd0, rdata);
        end
        finish_test("unmapped region");

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && !bus_stalled) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verification
hdl/bus_pkg.sv
hdl/mmio_map_pkg.sv
hdl/mmio_decoder.sv
hdl/bus_transaction_fsm.sv
hdl/dsp_multiplier.sv
hdl/io_registers.sv
hdl/peripheral_bus.sv
verification/tb_peripheral_bus.sv
